/* project.f */
src/lab_bus_pkg.sv
src/lab_ops_pkg.sv
src/lab_regs.sv
src/tick_counter.sv
src/seg_display.sv
src/alu_4bit.sv
src/lab_top.sv
tests/lab_checker.sv
tests/tb_lab_top.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_lab_top -Mdir obj_dir -f project.f
./obj_dir/Vtb_lab_top > sim.log 2>&1
cat sim.log
if grep -q "TESTBENCH PASSED" sim.log; then
	echo "simulation ok"
else
	echo "simulation reported a failure"
	exit 1
fi

/* tests/tb_lab_top.sv */
`timescale 1ns/1ps

module tb_lab_top;
	import lab_bus_pkg::*;
	import lab_ops_pkg::*;

	typedef enum logic [1:0] {k_write, k_read, k_wait} row_kind_e;

	typedef struct {
		row_kind_e kind;
		logic [7:0] addr;
		logic [31:0] data;
		logic [31:0] exp_data;
		logic exp_err;
	} row_t;

	logic clk;
	logic rst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [addr_w-1:0] paddr;
	logic [data_w-1:0] pwdata;
	logic [data_w-1:0] prdata;
	logic pready;
	logic pslverr;
	logic [count_w-1:0] count;
	logic [seg_w-1:0] seg_tens;
	logic [seg_w-1:0] seg_ones;
	logic [nib_w-1:0] alu_res;
	logic alu_zero;
	logic alu_overflow;
	logic alu_carry;
	logic exp_valid;
	logic [data_w-1:0] exp_rdata;
	logic exp_slverr;
	int bus_errors;
	int value_errors;
	row_t table_q[$];
	row_t row;
	int seed;
	int cycles = 0;
	int cycle_limit = 0;
	int longest_wait = 0;

	always #4 clk = ~clk;

	lab_top i_dut (
		.clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.count(count), .seg_tens(seg_tens), .seg_ones(seg_ones), .alu_res(alu_res),
		.alu_zero(alu_zero), .alu_overflow(alu_overflow), .alu_carry(alu_carry)
	);

	lab_checker i_checker (
		.clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.count(count), .seg_tens(seg_tens), .seg_ones(seg_ones), .alu_res(alu_res),
		.alu_zero(alu_zero), .alu_overflow(alu_overflow), .alu_carry(alu_carry),
		.exp_valid(exp_valid), .exp_rdata(exp_rdata), .exp_slverr(exp_slverr),
		.bus_errors(bus_errors), .value_errors(value_errors)
	);

	task automatic add_row(input row_kind_e kind, input logic [7:0] addr, input logic [31:0] data,
		input logic [31:0] exp_data, input logic exp_err);
		row_t r;
		r.kind = kind;
		r.addr = addr;
		r.data = data;
		r.exp_data = exp_data;
		r.exp_err = exp_err;
		table_q.push_back(r);
		if (kind == k_wait && int'(data) > longest_wait) begin
			longest_wait = int'(data);
		end
	endtask

	// operand write followed by a result read.
	task automatic add_alu_case(input logic [31:0] oper, input logic [31:0] result);
		add_row(k_write, reg_alu_oper, oper, 32'h0, 1'b0);
		add_row(k_read, reg_alu_result, 32'h0, result, 1'b0);
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic err);
		@(negedge clk);
		psel = 1'b1;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		exp_valid = 1'b1;
		exp_slverr = err;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		exp_valid = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, input logic [31:0] data, input logic err);
		@(negedge clk);
		psel = 1'b1;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clk);
		penable = 1'b1;
		exp_valid = 1'b1;
		exp_rdata = data;
		exp_slverr = err;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		exp_valid = 1'b0;
	endtask

	task automatic build_table();
		logic [31:0] oper;
		// ********************************************************************
		// reset defaults and fixed alu cases
		// ********************************************************************
		add_row(k_read, reg_ctrl, 32'h0, 32'h0, 1'b0);
		add_row(k_read, reg_prescale, 32'h0, 32'h0, 1'b0);
		add_row(k_read, reg_count, 32'h0, 32'h0, 1'b0);
		add_row(k_read, reg_alu_result, 32'h0, 32'h10, 1'b0);
		add_alu_case(32'h089, 32'h61);
		add_alu_case(32'h035, 32'h28);
		add_alu_case(32'h01f, 32'h50);
		add_alu_case(32'h153, 32'h0e);
		add_alu_case(32'h118, 32'h67);
		add_alu_case(32'h62d, 32'h01);
		add_alu_case(32'h6d2, 32'h10);
		add_alu_case(32'h777, 32'h01);
		add_alu_case(32'h767, 32'h10);
		add_row(k_read, reg_alu_oper, 32'h0, 32'h767, 1'b0);
		for (int i = 0; i < 32; i++) begin
			oper = $random(seed);
			oper = oper & 32'h7ff;
			add_alu_case(oper, {25'd0, i_checker.alu_model(oper[3:0], oper[7:4],
				alu_op_e'(oper[10:8]))});
		end
		// ********************************************************************
		// counter cadence, clear, wrap and bus errors
		// ********************************************************************
		add_row(k_write, reg_prescale, 32'd3, 32'h0, 1'b0);
		add_row(k_write, reg_ctrl, 32'h1, 32'h0, 1'b0);
		add_row(k_wait, 8'h00, 32'd40, 32'h0, 1'b0);
		add_row(k_write, reg_ctrl, 32'h0, 32'h0, 1'b0);
		add_row(k_wait, 8'h00, 32'd5, 32'h0, 1'b0);
		add_row(k_read, reg_count, 32'h0, 32'h0a, 1'b0);
		add_row(k_write, reg_ctrl, 32'h1, 32'h0, 1'b0);
		add_row(k_wait, 8'h00, 32'd10, 32'h0, 1'b0);
		add_row(k_write, reg_ctrl, 32'h3, 32'h0, 1'b0);
		add_row(k_wait, 8'h00, 32'd10, 32'h0, 1'b0);
		add_row(k_write, reg_ctrl, 32'h2, 32'h0, 1'b0);
		add_row(k_read, reg_count, 32'h0, 32'h0, 1'b0);
		add_row(k_read, reg_ctrl, 32'h0, 32'h0, 1'b0);
		add_row(k_write, reg_prescale, 32'd0, 32'h0, 1'b0);
		add_row(k_write, reg_ctrl, 32'h1, 32'h0, 1'b0);
		add_row(k_wait, 8'h00, 32'd110, 32'h0, 1'b0);
		add_row(k_write, reg_ctrl, 32'h0, 32'h0, 1'b0);
		add_row(k_read, reg_count, 32'h0, 32'h0d, 1'b0);
		add_row(k_write, reg_alu_oper, 32'h089, 32'h0, 1'b0);
		add_row(k_read, 8'h14, 32'h0, 32'h0, 1'b1);
		add_row(k_read, 8'h03, 32'h0, 32'h0, 1'b1);
		add_row(k_write, reg_count, 32'h55, 32'h0, 1'b1);
		add_row(k_write, reg_alu_result, 32'h7f, 32'h0, 1'b1);
		add_row(k_write, 8'h20, 32'h1, 32'h0, 1'b1);
		add_row(k_read, reg_count, 32'h0, 32'h0d, 1'b0);
		add_row(k_read, reg_alu_result, 32'h0, 32'h61, 1'b0);
		add_row(k_read, reg_ctrl, 32'h0, 32'h0, 1'b0);
		add_row(k_read, reg_prescale, 32'h0, 32'h0, 1'b0);
	endtask

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("the run timed out after %0d cycles", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		exp_valid = 1'b0;
		exp_rdata = '0;
		exp_slverr = 1'b0;
		seed = 32'hcf4;
		build_table();
		cycle_limit = table_q.size() * 4 + longest_wait + 200;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		foreach (table_q[i]) begin
			row = table_q[i];
			case (row.kind)
				k_write: apb_write(row.addr, row.data, row.exp_err);
				k_read: apb_read(row.addr, row.exp_data, row.exp_err);
				default: repeat (int'(row.data)) @(negedge clk);
			endcase
		end
		repeat (4) @(negedge clk);
		$display("bus errors: %0d, value errors: %0d", bus_errors, value_errors);
		if (bus_errors == 0 && value_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* tests/lab_checker.sv */
`timescale 1ns/1ps

module lab_checker (
	input  logic clk,
	input  logic rst_n,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [lab_bus_pkg::addr_w-1:0] paddr,
	input  logic [lab_bus_pkg::data_w-1:0] pwdata,
	input  logic [lab_bus_pkg::data_w-1:0] prdata,
	input  logic pready,
	input  logic pslverr,
	input  logic [lab_ops_pkg::count_w-1:0] count,
	input  logic [lab_ops_pkg::seg_w-1:0] seg_tens,
	input  logic [lab_ops_pkg::seg_w-1:0] seg_ones,
	input  logic [lab_ops_pkg::nib_w-1:0] alu_res,
	input  logic alu_zero,
	input  logic alu_overflow,
	input  logic alu_carry,
	input  logic exp_valid,
	input  logic [lab_bus_pkg::data_w-1:0] exp_rdata,
	input  logic exp_slverr,
	output int bus_errors,
	output int value_errors
);
	import lab_bus_pkg::*;
	import lab_ops_pkg::*;

	// active low patterns in g down to a order.
	localparam logic [seg_w-1:0] seg_table [0:9] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78, 7'h00, 7'h10
	};

	int n_bus = 0;
	int n_value = 0;
	logic m_run;
	logic m_clear;
	logic [prescale_w-1:0] m_prescale;
	logic [prescale_w-1:0] m_psc;
	logic [count_w-1:0] m_count;
	logic [count_w-1:0] m_shown;
	logic [nib_w-1:0] m_a;
	logic [nib_w-1:0] m_b;
	alu_op_e m_op;
	logic [6:0] alu_exp;
	logic access;
	logic wr;
	logic tick;

	assign bus_errors = n_bus;
	assign value_errors = n_value;

	// result word laid out as in reg_alu_result.
	function automatic logic [6:0] alu_model(input logic [3:0] a, input logic [3:0] b,
		input alu_op_e op);
		logic [4:0] s;
		logic [3:0] r;
		logic c;
		logic v;
		s = '0;
		c = 1'b0;
		v = 1'b0;
		case (op)
			op_add: begin
				s = {1'b0, a} + {1'b0, b};
				v = (a[3] == b[3]) && (s[3] != a[3]);
			end
			op_sub: begin
				s = {1'b0, a} + {1'b0, ~b} + 5'd1;
				v = (a[3] != b[3]) && (s[3] != a[3]);
			end
			default: s = '0;
		endcase
		case (op)
			op_add, op_sub: begin
				r = s[3:0];
				c = s[4];
			end
			op_not: r = ~a;
			op_and: r = a & b;
			op_or: r = a | b;
			op_xor: r = a ^ b;
			op_lt: r = {3'b000, $signed(a) < $signed(b)};
			default: r = {3'b000, a == b};
		endcase
		return {c, v, r == 4'd0, r};
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act, input bit on_bus);
		if (exp !== act) begin
			$display("CHECK FAILED %s expected 0x%0h actual 0x%0h at %0t", name, exp, act, $time);
			if (on_bus) begin
				n_bus++;
			end else begin
				n_value++;
			end
		end
	endtask

	// ********************************************************************
	// compare, then advance the model by one edge
	// ********************************************************************

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			m_run = 1'b0;
			m_clear = 1'b0;
			m_prescale = '0;
			m_psc = '0;
			m_count = '0;
			m_shown = '0;
			m_a = '0;
			m_b = '0;
			m_op = op_add;
		end else begin
			access = psel && penable;
			wr = access && pwrite && (paddr inside {reg_ctrl, reg_prescale, reg_alu_oper});
			check_value("pready", 32'd1, 32'(pready), 1'b1);
			if (pslverr && !access) begin
				$display("pslverr was raised outside an access phase at %0t", $time);
				n_bus++;
			end
			if (access && exp_valid) begin
				check_value("pslverr", 32'(exp_slverr), 32'(pslverr), 1'b1);
				if (!pwrite) begin
					check_value("prdata", exp_rdata, prdata, 1'b1);
				end
			end
			check_value("count", 32'(m_count), 32'(count), 1'b0);
			check_value("seg_tens", 32'(seg_table[nib_w'(m_shown / count_w'(10))]),
				32'(seg_tens), 1'b0);
			check_value("seg_ones", 32'(seg_table[nib_w'(m_shown % count_w'(10))]),
				32'(seg_ones), 1'b0);
			alu_exp = alu_model(m_a, m_b, m_op);
			check_value("alu_res", 32'(alu_exp[3:0]), 32'(alu_res), 1'b0);
			check_value("alu_zero", 32'(alu_exp[4]), 32'(alu_zero), 1'b0);
			check_value("alu_overflow", 32'(alu_exp[5]), 32'(alu_overflow), 1'b0);
			check_value("alu_carry", 32'(alu_exp[6]), 32'(alu_carry), 1'b0);

			m_shown = m_count;
			tick = m_run && (m_psc == m_prescale);
			if (m_clear) begin
				m_count = '0;
				m_psc = '0;
			end else if (tick) begin
				m_psc = '0;
				m_count = (m_count == count_w'(count_max)) ? '0 : m_count + 1'b1;
			end else if (m_run) begin
				m_psc = m_psc + 1'b1;
			end

			m_clear = 1'b0;
			if (wr && paddr == reg_ctrl) begin
				m_run = pwdata[ctrl_run_bit];
				m_clear = pwdata[ctrl_clear_bit];
			end
			if (wr && paddr == reg_prescale) begin
				m_prescale = pwdata[prescale_w-1:0];
			end
			if (wr && paddr == reg_alu_oper) begin
				m_a = pwdata[oper_a_lsb +: nib_w];
				m_b = pwdata[oper_b_lsb +: nib_w];
				m_op = alu_op_e'(pwdata[oper_op_lsb +: 3]);
			end
		end
	end

endmodule

/* src/lab_top.sv */
`timescale 1ns/1ps

module lab_top (
	input  logic clk,
	input  logic rst_n,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [lab_bus_pkg::addr_w-1:0] paddr,
	input  logic [lab_bus_pkg::data_w-1:0] pwdata,
	output logic [lab_bus_pkg::data_w-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic [lab_ops_pkg::count_w-1:0] count,
	output logic [lab_ops_pkg::seg_w-1:0] seg_tens,
	output logic [lab_ops_pkg::seg_w-1:0] seg_ones,
	output logic [lab_ops_pkg::nib_w-1:0] alu_res,
	output logic alu_zero,
	output logic alu_overflow,
	output logic alu_carry
);
	import lab_bus_pkg::*;
	import lab_ops_pkg::*;

	logic run;
	logic clear_pulse;
	logic [prescale_w-1:0] prescale;
	logic [nib_w-1:0] alu_a;
	logic [nib_w-1:0] alu_b;
	alu_op_e alu_op;

	// ********************************************************************
	// register block and datapath
	// ********************************************************************

	lab_regs i_regs (
		.clk(clk),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.count(count),
		.alu_res(alu_res),
		.alu_zero(alu_zero),
		.alu_overflow(alu_overflow),
		.alu_carry(alu_carry),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.run(run),
		.clear_pulse(clear_pulse),
		.prescale(prescale),
		.alu_a(alu_a),
		.alu_b(alu_b),
		.alu_op(alu_op)
	);

	tick_counter i_counter (
		.clk(clk),
		.rst_n(rst_n),
		.run(run),
		.clear_pulse(clear_pulse),
		.prescale(prescale),
		.count(count)
	);

	// display lags the count by one cycle.
	seg_display i_display (
		.clk(clk),
		.rst_n(rst_n),
		.count(count),
		.seg_tens(seg_tens),
		.seg_ones(seg_ones)
	);

	alu_4bit i_alu (
		.alu_a(alu_a),
		.alu_b(alu_b),
		.alu_op(alu_op),
		.alu_res(alu_res),
		.alu_zero(alu_zero),
		.alu_overflow(alu_overflow),
		.alu_carry(alu_carry)
	);

endmodule

/* src/alu_4bit.sv */
`timescale 1ns/1ps

module alu_4bit (
	input  logic [lab_ops_pkg::nib_w-1:0] alu_a,
	input  logic [lab_ops_pkg::nib_w-1:0] alu_b,
	input  lab_ops_pkg::alu_op_e alu_op,
	output logic [lab_ops_pkg::nib_w-1:0] alu_res,
	output logic alu_zero,
	output logic alu_overflow,
	output logic alu_carry
);
	import lab_ops_pkg::*;

	logic is_sub;
	logic [nib_w-1:0] b_eff;
	logic [nib_w:0] sum;

	// a - b is a + ~b + 1 on the same adder.
	assign is_sub = (alu_op == op_sub);
	assign b_eff = is_sub ? ~alu_b : alu_b;
	assign sum = {1'b0, alu_a} + {1'b0, b_eff} + {{nib_w{1'b0}}, is_sub};

	always_comb begin
		alu_res = '0;
		alu_carry = 1'b0;
		alu_overflow = 1'b0;
		case (alu_op)
			op_add, op_sub: begin
				alu_res = sum[nib_w-1:0];
				alu_carry = sum[nib_w];
				// operands of equal sign giving a result of the other sign.
				alu_overflow = (alu_a[nib_w-1] == b_eff[nib_w-1]) &&
					(sum[nib_w-1] != alu_a[nib_w-1]);
			end
			op_not: alu_res = ~alu_a;
			op_and: alu_res = alu_a & alu_b;
			op_or:  alu_res = alu_a | alu_b;
			op_xor: alu_res = alu_a ^ alu_b;
			op_lt: begin
				alu_res = {{(nib_w-1){1'b0}}, ($signed(alu_a) < $signed(alu_b))};
			end
			op_eq: begin
				alu_res = {{(nib_w-1){1'b0}}, (alu_a == alu_b)};
			end
			default: alu_res = '0;
		endcase
	end

	assign alu_zero = (alu_res == '0);

endmodule

/* src/seg_display.sv */
`timescale 1ns/1ps

module seg_display (
	input  logic clk,
	input  logic rst_n,
	input  logic [lab_ops_pkg::count_w-1:0] count,
	output logic [lab_ops_pkg::seg_w-1:0] seg_tens,
	output logic [lab_ops_pkg::seg_w-1:0] seg_ones
);
	import lab_ops_pkg::*;

	logic [count_w-1:0] tens_wide;
	logic [count_w-1:0] ones_wide;

	// active low segments in g down to a order.
	function automatic logic [seg_w-1:0] seg_pattern(input logic [nib_w-1:0] digit);
		case (digit)
			4'd0: seg_pattern = 7'h40;
			4'd1: seg_pattern = 7'h79;
			4'd2: seg_pattern = 7'h24;
			4'd3: seg_pattern = 7'h30;
			4'd4: seg_pattern = 7'h19;
			4'd5: seg_pattern = 7'h12;
			4'd6: seg_pattern = 7'h02;
			4'd7: seg_pattern = 7'h78;
			4'd8: seg_pattern = 7'h00;
			4'd9: seg_pattern = 7'h10;
			// blank
			default: seg_pattern = 7'h7f;
		endcase
	endfunction

	assign tens_wide = count / count_w'(10);
	assign ones_wide = count % count_w'(10);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			seg_tens <= seg_pattern('0);
			seg_ones <= seg_pattern('0);
		end else begin
			seg_tens <= seg_pattern(tens_wide[nib_w-1:0]);
			seg_ones <= seg_pattern(ones_wide[nib_w-1:0]);
		end
	end

endmodule

/* src/tick_counter.sv */
`timescale 1ns/1ps

module tick_counter (
	input  logic clk,
	input  logic rst_n,
	input  logic run,
	input  logic clear_pulse,
	input  logic [lab_bus_pkg::prescale_w-1:0] prescale,
	output logic [lab_ops_pkg::count_w-1:0] count
);
	import lab_bus_pkg::*;
	import lab_ops_pkg::*;

	logic [prescale_w-1:0] psc_cnt;
	logic tick;

	// one tick every prescale+1 running cycles.
	assign tick = run && (psc_cnt == prescale);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			psc_cnt <= '0;
		end else if (clear_pulse) begin
			psc_cnt <= '0;
		end else if (tick) begin
			psc_cnt <= '0;
		end else if (run) begin
			psc_cnt <= psc_cnt + 1'b1;
		end
	end

	// ********************************************************************
	// decimal event counter
	// ********************************************************************

	// clear wins over a tick in the same cycle.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (clear_pulse) begin
			count <= '0;
		end else if (tick) begin
			if (count == count_w'(count_max)) begin
				count <= '0;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

	a_count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		count <= count_w'(count_max));

	// a stopped counter holds its value.
	a_hold_when_stopped: assert property (@(posedge clk) disable iff (!rst_n)
		(!run && !clear_pulse) |=> $stable(count));

endmodule

/* src/lab_regs.sv */
`timescale 1ns/1ps

module lab_regs (
	input  logic clk,
	input  logic rst_n,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [lab_bus_pkg::addr_w-1:0] paddr,
	input  logic [lab_bus_pkg::data_w-1:0] pwdata,
	input  logic [lab_ops_pkg::count_w-1:0] count,
	input  logic [lab_ops_pkg::nib_w-1:0] alu_res,
	input  logic alu_zero,
	input  logic alu_overflow,
	input  logic alu_carry,
	output logic [lab_bus_pkg::data_w-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic run,
	output logic clear_pulse,
	output logic [lab_bus_pkg::prescale_w-1:0] prescale,
	output logic [lab_ops_pkg::nib_w-1:0] alu_a,
	output logic [lab_ops_pkg::nib_w-1:0] alu_b,
	output lab_ops_pkg::alu_op_e alu_op
);
	import lab_bus_pkg::*;
	import lab_ops_pkg::*;

	logic access;
	logic addr_mapped;
	logic addr_ro;
	logic wr_en;

	// no wait states.
	assign pready = 1'b1;
	assign access = psel & penable;

	always_comb begin
		addr_mapped = 1'b0;
		addr_ro = 1'b0;
		case (paddr)
			reg_ctrl, reg_prescale, reg_alu_oper: addr_mapped = 1'b1;
			reg_alu_result, reg_count: begin
				addr_mapped = 1'b1;
				addr_ro = 1'b1;
			end
			default: addr_mapped = 1'b0;
		endcase
	end

	assign pslverr = access & (~addr_mapped | (pwrite & addr_ro));
	assign wr_en = access & pwrite & addr_mapped & ~addr_ro;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run <= 1'b0;
			clear_pulse <= 1'b0;
			prescale <= '0;
			alu_a <= '0;
			alu_b <= '0;
			alu_op <= op_add;
		end else begin
			clear_pulse <= 1'b0;
			if (wr_en) begin
				case (paddr)
					reg_ctrl: begin
						run <= pwdata[ctrl_run_bit];
						clear_pulse <= pwdata[ctrl_clear_bit];
					end
					reg_prescale: prescale <= pwdata[prescale_w-1:0];
					reg_alu_oper: begin
						alu_a <= pwdata[oper_a_lsb +: nib_w];
						alu_b <= pwdata[oper_b_lsb +: nib_w];
						alu_op <= alu_op_e'(pwdata[oper_op_lsb +: $bits(alu_op_e)]);
					end
					default: run <= run;
				endcase
			end
		end
	end

	// ********************************************************************
	// read mux
	// ********************************************************************

	always_comb begin
		prdata = '0;
		if (access && !pwrite) begin
			case (paddr)
				reg_ctrl: prdata[ctrl_run_bit] = run;
				reg_prescale: prdata[prescale_w-1:0] = prescale;
				reg_alu_oper: begin
					prdata[oper_a_lsb +: nib_w] = alu_a;
					prdata[oper_b_lsb +: nib_w] = alu_b;
					prdata[oper_op_lsb +: $bits(alu_op_e)] = alu_op;
				end
				reg_alu_result: begin
					prdata[res_val_lsb +: nib_w] = alu_res;
					prdata[res_zero_bit] = alu_zero;
					prdata[res_ovf_bit] = alu_overflow;
					prdata[res_carry_bit] = alu_carry;
				end
				reg_count: prdata[count_w-1:0] = count;
				default: prdata = '0;
			endcase
		end
	end

	// the clear request lasts exactly one cycle.
	a_clear_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		clear_pulse |=> !clear_pulse);

	a_slverr_in_access: assert property (@(posedge clk) disable iff (!rst_n)
		pslverr |-> (psel && penable && pready));

endmodule

/* src/lab_ops_pkg.sv */
package lab_ops_pkg;

	// ********************************************************************
	// datapath widths and limits
	// ********************************************************************

	localparam int nib_w = 4;
	localparam int count_w = 7;
	localparam int seg_w = 7;

	// decimal counter wraps after this value.
	localparam int count_max = 99;

	// ********************************************************************
	// alu opcodes
	// ********************************************************************

	typedef enum logic [2:0] {
		op_add = 3'd0,
		op_sub = 3'd1,
		op_not = 3'd2,
		op_and = 3'd3,
		op_or  = 3'd4,
		op_xor = 3'd5,
		// signed compare.
		op_lt  = 3'd6,
		op_eq  = 3'd7
	} alu_op_e;

endpackage

/* src/lab_bus_pkg.sv */
package lab_bus_pkg;

	// APB widths.
	localparam int addr_w = 8;
	localparam int data_w = 32;

	// ********************************************************************
	// register map
	// ********************************************************************

	localparam logic [addr_w-1:0] reg_ctrl       = 8'h00;
	localparam logic [addr_w-1:0] reg_prescale   = 8'h04;
	localparam logic [addr_w-1:0] reg_alu_oper   = 8'h08;
	// read-only status registers.
	localparam logic [addr_w-1:0] reg_alu_result = 8'h0c;
	localparam logic [addr_w-1:0] reg_count      = 8'h10;

	localparam int prescale_w = 16;

	// clear is write-only and self-clearing.
	localparam int ctrl_run_bit   = 0;
	localparam int ctrl_clear_bit = 1;

	// alu operand fields.
	localparam int oper_a_lsb  = 0;
	localparam int oper_b_lsb  = 4;
	localparam int oper_op_lsb = 8;

	// alu result fields.
	localparam int res_val_lsb   = 0;
	localparam int res_zero_bit  = 4;
	localparam int res_ovf_bit   = 5;
	localparam int res_carry_bit = 6;

endpackage
